// ==== rtl/fetch_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types and constants of the instruction fetch front end
// Address, instruction, memory block and memory tag types
// Memory bus command encoding
// Instruction cache geometry and memory tag count
//////////////////////////////////////////////////////////////////////

`default_nettype none

package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // Basic data types
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] addr_t;      // Byte address
    typedef logic [31:0] inst_t;      // One instruction word

    // One memory block of two words
    // Bits 31..0 hold the word at the aligned address
    // Bits 63..32 hold the word at aligned address plus 4
    typedef logic [63:0] mem_block_t;

    // Memory transaction tag
    // Zero marks no transaction, 1 to 15 mark live loads
    typedef logic [3:0] mem_tag_t;

    //////////////////////////////////////////////////////////////////////
    // Memory bus commands
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,             // Idle bus
        BUS_LOAD  = 2'h1,             // Block read
        BUS_STORE = 2'h2              // Block write, unused by fetch
    } mem_command_e;

    //////////////////////////////////////////////////////////////////////
    // Cache geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ICACHE_LINES       = 32;
    localparam int ICACHE_INDEX_BITS  = 5;   // log2 of the line count
    localparam int ICACHE_OFFSET_BITS = 3;   // Byte offset within a block
    // Tag, index and offset together cover address bits 15..0
    localparam int ICACHE_TAG_BITS    = 8;

    // Loads that memory can keep in flight at once
    localparam int MEM_TAG_COUNT      = 15;

endpackage

`default_nettype wire

// ==== rtl/icache.sv ====
//////////////////////////////////////////////////////////////////////
// Direct mapped blocking instruction cache
// 32 lines of one 8 byte block each
// Hit lookup is combinational on the fetch address
// Misses retry a load until memory grants a tag, then fill on the
// matching data tag and drop the wait when the address moves
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module icache (
    input  logic                     clock,
    input  logic                     reset,

    // Fetch side
    input  fetch_pkg::addr_t         fetch_addr,
    output fetch_pkg::mem_block_t    block,         // Block holding fetch_addr
    output logic                     hit,           // block is valid

    // Memory side
    output fetch_pkg::mem_command_e  mem_command,
    output fetch_pkg::addr_t         mem_addr,
    input  fetch_pkg::mem_tag_t      mem_transaction_tag,   // Grant, 0 if refused
    input  fetch_pkg::mem_block_t    mem_data,
    input  fetch_pkg::mem_tag_t      mem_data_tag           // 0 unless data returns
);

    import fetch_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Line storage
    //////////////////////////////////////////////////////////////////////

    mem_block_t                   line_data [ICACHE_LINES];
    logic [ICACHE_TAG_BITS-1:0]   line_tag  [ICACHE_LINES];
    logic [ICACHE_LINES-1:0]      line_valid;

    //////////////////////////////////////////////////////////////////////
    // Address split and lookup
    //////////////////////////////////////////////////////////////////////

    logic [ICACHE_TAG_BITS-1:0]   cur_tag;
    logic [ICACHE_INDEX_BITS-1:0] cur_index;
    logic [ICACHE_TAG_BITS-1:0]   last_tag;     // Address seen last cycle
    logic [ICACHE_INDEX_BITS-1:0] last_index;

    assign cur_index = fetch_addr[ICACHE_OFFSET_BITS +: ICACHE_INDEX_BITS];
    assign cur_tag   = fetch_addr[ICACHE_OFFSET_BITS + ICACHE_INDEX_BITS +: ICACHE_TAG_BITS];

    assign block = line_data[cur_index];
    assign hit   = line_valid[cur_index] && (line_tag[cur_index] == cur_tag);

    //////////////////////////////////////////////////////////////////////
    // Miss tracking
    //////////////////////////////////////////////////////////////////////

    mem_tag_t saved_tag;          // Memory tag of the pending fill
    logic     miss_outstanding;   // Load still waiting for a grant
    mem_tag_t granted_tag;        // Grant seen this cycle, 0 without a load
    logic     changed_addr;
    logic     got_mem_data;
    logic     update_saved_tag;
    logic     unanswered_miss;

    assign changed_addr = (cur_index != last_index) || (cur_tag != last_tag);

    // Memory only grants against a load in the same cycle
    assign granted_tag = (mem_command == BUS_LOAD) ? mem_transaction_tag : '0;

    // Fill only for the address the tag was granted for
    // Data landing in the cycle of an address change belongs to the old one
    assign got_mem_data = (saved_tag != '0) && (saved_tag == mem_data_tag)
                          && !changed_addr;

    // Drop the tag on a change, capture the grant while asking,
    // clear it once the data is in
    assign update_saved_tag = changed_addr || miss_outstanding || got_mem_data;

    // A new address asks for a load only if it misses
    // An old miss keeps asking while memory refuses
    assign unanswered_miss = changed_addr ? !hit
                                          : (miss_outstanding && (granted_tag == '0));

    // Repeat the load every cycle until a tag is granted
    assign mem_command = (miss_outstanding && !changed_addr) ? BUS_LOAD : BUS_NONE;
    assign mem_addr    = {fetch_addr[31:ICACHE_OFFSET_BITS], {ICACHE_OFFSET_BITS{1'b0}}};

    //////////////////////////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            last_tag         <= '1;     // First cycle out of reset looks like a move
            last_index       <= '1;
            saved_tag        <= '0;
            miss_outstanding <= 1'b0;
            line_valid       <= '0;     // Cache starts empty
        end else begin
            last_tag         <= cur_tag;
            last_index       <= cur_index;
            miss_outstanding <= unanswered_miss;
            if (update_saved_tag) begin
                saved_tag <= granted_tag;
            end
            if (got_mem_data) begin
                line_valid[cur_index] <= 1'b1;  // hit rises next cycle
            end
        end
    end

    // Line payload
    always_ff @(posedge clock) begin
        if (got_mem_data) begin
            line_data[cur_index] <= mem_data;
            line_tag[cur_index]  <= cur_tag;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Fetch never writes memory
    a_no_store : assert property (@(posedge clock) disable iff (reset)
        mem_command != BUS_STORE);

    // Data without a live tag never writes a line
    a_fill_tag : assert property (@(posedge clock) disable iff (reset)
        (mem_data_tag == '0) |=> $stable(line_valid));

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch stage
// Program counter with redirect from a later stage
// Word select from the cached block and the instruction strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  logic                   clock,
    input  logic                   reset,

    // Later stage
    input  logic                   redirect,      // One cycle pulse
    input  fetch_pkg::addr_t       redirect_pc,

    // Cache side
    output fetch_pkg::addr_t       fetch_addr,
    input  fetch_pkg::mem_block_t  block,
    input  logic                   hit,

    // Decode side
    output fetch_pkg::inst_t       inst,
    output fetch_pkg::addr_t       inst_pc,
    output logic                   inst_valid     // One cycle per instruction
);

    import fetch_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////////////////////////

    addr_t pc;
    addr_t pc_step;             // Next sequential instruction
    addr_t redirect_target;     // Redirect address on a word boundary
    logic  take_inst;           // Instruction leaves this cycle

    assign pc_step         = pc + 32'd4;
    assign redirect_target = {redirect_pc[31:2], 2'b00};

    // A redirect in the same cycle wins over the hit
    assign take_inst = hit && !redirect;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;                       // Fetch starts at address 0
        end else if (redirect) begin
            pc <= redirect_target;
        end else if (take_inst) begin
            pc <= pc_step;
        end
    end

    assign fetch_addr = pc;

    //////////////////////////////////////////////////////////////////////
    // Instruction select
    //////////////////////////////////////////////////////////////////////

    inst_t inst_lo;       // Word at the aligned address
    inst_t inst_hi;       // Word at aligned address plus 4
    logic  word_sel;

    assign inst_lo  = block[31:0];
    assign inst_hi  = block[63:32];
    assign word_sel = pc[2];

    always_comb begin
        if (word_sel) begin
            inst = inst_hi;
        end else begin
            inst = inst_lo;
        end
    end

    assign inst_pc    = pc;
    assign inst_valid = take_inst;    // Strobe lines up with the PC step

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // PC stays on a word boundary through steps and redirects
    a_pc_aligned : assert property (@(posedge clock) disable iff (reset)
        fetch_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rtl/fetch_top.sv ====
//////////////////////////////////////////////////////////////////////
// Instruction fetch front end top level
// Fetch stage and instruction cache
// Memory bus and fetch outputs as plain ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fetch_top (
    input  logic                     clock,
    input  logic                     reset,

    // Later stage
    input  logic                     redirect,
    input  fetch_pkg::addr_t         redirect_pc,

    // Fetched instruction
    output fetch_pkg::inst_t         inst,
    output fetch_pkg::addr_t         inst_pc,
    output logic                     inst_valid,

    // Memory bus
    output fetch_pkg::mem_command_e  mem_command,
    output fetch_pkg::addr_t         mem_addr,       // Block aligned PC
    input  fetch_pkg::mem_tag_t      mem_transaction_tag,
    input  fetch_pkg::mem_block_t    mem_data,
    input  fetch_pkg::mem_tag_t      mem_data_tag
);

    import fetch_pkg::*;

    addr_t      fetch_addr;     // Current PC into the cache
    mem_block_t block;          // Block out of the cache
    logic       hit;

    // PC, redirect and word select
    fetch_unit i_fetch_unit (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_addr  (fetch_addr),
        .block       (block),
        .hit         (hit),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_valid  (inst_valid)
    );

    // Line store and miss handling
    icache i_icache (
        .clock               (clock),
        .reset               (reset),
        .fetch_addr          (fetch_addr),
        .block               (block),
        .hit                 (hit),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag)
    );

endmodule

`default_nettype wire

// ==== sim/tagged_mem_model.sv ====
//////////////////////////////////////////////////////////////////////
// Behavioral tagged memory for the fetch front end
// Grants loads with rotating tags 1 to 15, refuses some at random
// Returns each block a fixed number of cycles after the grant
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tagged_mem_model #(
    parameter int               LATENCY        = 1,    // Grant cycle to data cycle
    parameter int               REFUSE_PERCENT = 0,    // Chance of tag 0 per load
    parameter fetch_pkg::inst_t PATTERN        = '0    // Word at A is A ^ PATTERN
) (
    input  logic                     clock,
    input  logic                     reset,
    input  fetch_pkg::mem_command_e  mem_command,
    input  fetch_pkg::addr_t         mem_addr,
    output fetch_pkg::mem_tag_t      mem_transaction_tag,
    output fetch_pkg::mem_block_t    mem_data,
    output fetch_pkg::mem_tag_t      mem_data_tag
);

    import fetch_pkg::*;

    mem_tag_t next_tag = 4'd1;                       // Tag for the next grant
    logic     refuse   = 1'b0;                       // Refuse any load this cycle
    mem_tag_t pipe_tag  [LATENCY] = '{default: '0};  // Loads in flight, 0 if empty
    addr_t    pipe_addr [LATENCY] = '{default: '0};
    addr_t    ret_addr;                              // Block coming back now

    // Grant in the same cycle as the load command
    assign mem_transaction_tag = ((mem_command == BUS_LOAD) && !refuse) ? next_tag : '0;

    //////////////////////////////////////////////////////////////////////
    // Tag rotation and latency pipe
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (reset) begin
            next_tag <= 4'd1;
            refuse   <= 1'b0;
            for (int i = 0; i < LATENCY; i++) begin
                pipe_tag[i]  <= '0;
                pipe_addr[i] <= '0;
            end
        end else begin
            refuse <= ($urandom_range(99) < REFUSE_PERCENT);   // Loses to a data cache
            if (mem_transaction_tag != '0) begin
                // Wrap after the last live tag, never hand out 0
                next_tag <= (next_tag == mem_tag_t'(MEM_TAG_COUNT)) ? 4'd1 : next_tag + 4'd1;
            end
            pipe_tag[0]  <= mem_transaction_tag;   // Zero when nothing was granted
            pipe_addr[0] <= mem_addr;
            for (int i = 1; i < LATENCY; i++) begin
                pipe_tag[i]  <= pipe_tag[i-1];
                pipe_addr[i] <= pipe_addr[i-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Return side
    //////////////////////////////////////////////////////////////////////

    assign ret_addr     = pipe_addr[LATENCY-1];
    assign mem_data_tag = pipe_tag[LATENCY-1];     // One cycle per load

    always_comb begin
        if (mem_data_tag != '0) begin
            // Upper word at block address plus 4
            mem_data = {(ret_addr + 32'd4) ^ PATTERN, ret_addr ^ PATTERN};
        end else begin
            mem_data = '0;
        end
    end

endmodule

`default_nettype wire

// ==== sim/fetch_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the instruction fetch front end
// Clock, reset, tagged memory model and redirect table
// Expected PC stream and compare tasks for each result type
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

    import fetch_pkg::*;

    localparam int    CLOCK_PERIOD   = 4;
    localparam int    RESET_CYCLES   = 16;
    localparam int    MEM_LATENCY    = 6;
    localparam int    REFUSE_PERCENT = 25;
    localparam int    TIMEOUT_CYCLES = 200;          // Per wait for inst_valid
    localparam int    SEED           = 32'h5eae_ee0e;
    localparam inst_t PATTERN        = 32'hC0DE_0000;

    // One table row: accept, idle, then maybe redirect
    typedef struct packed {
        int    count;     // Instructions to accept
        logic  jump;      // Drive a redirect after the idle cycles
        addr_t target;
        int    idle;      // Cycles without redirect before it
    } step_t;

    localparam int    STEP_COUNT = 11;
    localparam step_t STEP_TABLE [STEP_COUNT] = '{
        '{12, 1'b1, 32'h0000_0004, 0},   // Cold fetch over six blocks, back to 0x4
        '{10, 1'b1, 32'h0000_0010, 0},   // Reuse of cached blocks
        '{40, 1'b1, 32'h0000_1000, 3},   // Long stream, redirect while 0xB0 misses
        '{6,  1'b1, 32'h0000_2000, 2},   // Again in mid miss
        '{4,  1'b1, 32'h0000_0400, 0},
        '{2,  1'b1, 32'h0000_0500, 0},   // Same index as 0x400
        '{2,  1'b1, 32'h0000_0400, 0},
        '{2,  1'b1, 32'h0000_0504, 0},   // Upper word of the conflicting block
        '{1,  1'b1, 32'h0000_0400, 0},
        '{2,  1'b1, 32'h0000_00B0, 1},   // The block dropped earlier
        '{8,  1'b0, 32'h0000_0000, 0}
    };

    logic         clock;
    logic         reset;
    logic         redirect;
    addr_t        redirect_pc;
    inst_t        inst;
    addr_t        inst_pc;
    logic         inst_valid;
    mem_command_e mem_command;
    addr_t        mem_addr;
    mem_tag_t     mem_transaction_tag;
    mem_block_t   mem_data;
    mem_tag_t     mem_data_tag;

    addr_t expected_pc;       // Next PC that must show up
    logic  pair_pending;      // Lower word taken, upper due next cycle
    int    accepted;          // inst_valid pulses seen

    fetch_top i_dut (
        .clock               (clock),
        .reset               (reset),
        .redirect            (redirect),
        .redirect_pc         (redirect_pc),
        .inst                (inst),
        .inst_pc             (inst_pc),
        .inst_valid          (inst_valid),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag)
    );

    tagged_mem_model #(
        .LATENCY        (MEM_LATENCY),
        .REFUSE_PERCENT (REFUSE_PERCENT),
        .PATTERN        (PATTERN)
    ) i_mem (
        .clock               (clock),
        .reset               (reset),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compares
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_command(input string name, input mem_command_e got,
                                 input mem_command_e exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Cycle driver and monitor
    //////////////////////////////////////////////////////////////////////

    // Outputs are read at the falling edge, mid cycle
    task automatic check_cycle(input logic jump, input addr_t target);
        if (mem_command === BUS_LOAD) begin
            check_addr("mem_addr", mem_addr, {expected_pc[31:3], 3'b000});  // Block of the PC
        end
        if (jump) begin
            check_strobe("inst_valid", inst_valid, 1'b0);   // Redirect suppresses
            expected_pc  = {target[31:2], 2'b00};
            pair_pending = 1'b0;
        end else if (inst_valid === 1'b1) begin
            check_addr("inst_pc", inst_pc, expected_pc);
            check_inst("inst", inst, expected_pc ^ PATTERN);
            pair_pending = ~expected_pc[2];                  // Same block follows
            expected_pc  = expected_pc + 32'd4;
            accepted++;
        end else begin
            check_strobe("inst_valid", inst_valid, 1'b0);   // Catches X
            if (pair_pending) begin
                stop_run("Upper word of a cached block did not follow on the next cycle");
            end
        end
    endtask

    task automatic run_cycle(input logic jump, input addr_t target);
        @(posedge clock);
        redirect    <= jump;
        redirect_pc <= target;
        @(negedge clock);
        check_cycle(jump, target);
    endtask

    task automatic wait_for_inst();
        int start;
        int cycles;
        start  = accepted;
        cycles = 0;
        while (accepted == start) begin
            if (cycles == TIMEOUT_CYCLES) begin
                stop_run($sformatf("Timed out after %0d cycles waiting for inst_valid at 0x%08h",
                                   TIMEOUT_CYCLES, expected_pc));
            end
            run_cycle(1'b0, '0);
            cycles++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        reset        = 1'b1;
        redirect     = 1'b0;
        redirect_pc  = '0;
        expected_pc  = '0;      // Fetch starts at address 0
        pair_pending = 1'b0;
        accepted     = 0;

        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_cycle(1'b0, '0);  // First cycle out of reset
        check_command("mem_command", mem_command, BUS_NONE);   // Miss not seen yet

        for (int i = 0; i < STEP_COUNT; i++) begin
            for (int n = 0; n < STEP_TABLE[i].count; n++) begin
                wait_for_inst();
            end
            repeat (STEP_TABLE[i].idle) run_cycle(1'b0, '0);
            if (STEP_TABLE[i].jump) begin
                run_cycle(1'b1, STEP_TABLE[i].target);
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/fetch_pkg.sv
rtl/icache.sv
rtl/fetch_unit.sv
rtl/fetch_top.sv
sim/tagged_mem_model.sv
sim/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module fetch_tb -Mdir obj_dir -o fetch_sim -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/fetch_sim)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Verification passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
